/* filelist.f */
logic/addr_pkg.sv
logic/scan_ctrl_if.sv
logic/mode_tracker.sv
logic/conv_window_scan.sv
logic/pool_window_scan.sv
logic/write_addr_gen.sv
logic/addr_controller.sv
test/addr_controller_asserts.sv
test/addr_controller_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module addr_controller_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vaddr_controller_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* test/addr_controller_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_controller_tb;

    localparam int clk_half = 2;
    localparam int reset_cycles = 10;
    // Longest gap between strobes is 29 cycles in the 28-pixel pooling scan
    localparam int quiet_limit = 48;
    localparam int num_rows = 8;
    // All scans, restarts, waits and quiet windows come to about 4000 cycles
    localparam int est_test_cycles = 4000;
    localparam int max_cycles = 5 * est_test_cycles;

    typedef struct packed {
        addr_pkg::mode_t mode;
        int              read_addr;
        int              threshold;
        int              wait_cycles;
        int              expected;
        int              drop_after;
    } row_t;

    // mode, read address, start address, wait, valid count, en drop point
    localparam row_t rows [0:num_rows-1] = '{
        '{addr_pkg::mode_conv1, 172, 172, 8, 784, 0},
        '{addr_pkg::mode_conv2, 400, 156, 6, 576, 123},
        '{addr_pkg::mode_conv3, 100, 100, 12, 100, 0},
        '{addr_pkg::mode_conv4, 1000, 84, 5, 36, 20},
        '{addr_pkg::mode_conv5, 59, 59, 10, 1, 0},
        '{addr_pkg::mode_pool1, 87, 87, 7, 196, 50},
        '{addr_pkg::mode_pool2, 600, 33, 9, 25, 0},
        '{addr_pkg::mode_none, 2047, 2047, 16, 0, 0}
    };

    logic            clk;
    logic            rst_n;
    addr_pkg::mode_t ctrl_mode;
    addr_pkg::addr_t ctrl_read_addr;
    logic            en;
    addr_pkg::addr_t ctrl_write_addr;
    logic            valid_out;
    logic [15:0]     lfsr_state;
    int              cycle_cnt = 0;
    bit              fail_printed = 1'b0;
    bit              timed_out = 1'b0;
    bit              run_passed = 1'b0;

    addr_controller i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl_mode       (ctrl_mode),
        .ctrl_read_addr  (ctrl_read_addr),
        .en              (en),
        .ctrl_write_addr (ctrl_write_addr),
        .valid_out       (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            timed_out = 1'b1;
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("Result: FAILED");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    task automatic take_bits(input int nbits, output int value);
        int i;
        value = 0;
        for (i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            fail_printed = 1'b1;
            $display("ERROR @ %0t: %s, got %0d, expected %0d", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Outputs are read at the falling edge
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic apply_inputs(input addr_pkg::mode_t mode, input int addr, input logic en_val);
        @(posedge clk);
        ctrl_mode      <= mode;
        ctrl_read_addr <= addr_pkg::addr_t'(addr);
        en             <= en_val;
        @(negedge clk);
    endtask

    task automatic expect_quiet(input int ncycles, input string what);
        int i;
        for (i = 0; i < ncycles; i++) begin
            next_cycle();
            check_value(what, int'(valid_out), 0);
        end
    endtask

    // Ends after quiet_limit idle cycles, or at stop_at strobes when nonzero
    task automatic count_scan(input int base, input int stop_at, output int count);
        int quiet;
        quiet = 0;
        count = 0;
        while (quiet < quiet_limit && (stop_at == 0 || count < stop_at)) begin
            next_cycle();
            check_value("write address during scan", int'(ctrl_write_addr), base + count);
            if (valid_out) begin
                count++;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic pause_enable(input row_t row, input int frozen);
        int len;
        int i;
        take_bits(4, len);
        len = len + 3;
        apply_inputs(row.mode, row.read_addr, 1'b0);
        check_value("valid while en is low", int'(valid_out), 0);
        check_value("write address as en falls", int'(ctrl_write_addr), frozen);
        for (i = 1; i < len; i++) begin
            next_cycle();
            check_value("valid while en is low", int'(valid_out), 0);
            check_value("write address while en is low", int'(ctrl_write_addr), frozen);
        end
        apply_inputs(row.mode, row.read_addr, 1'b1);
    endtask

    task automatic run_row(input row_t row);
        int low_addr;
        int partial;
        int count;
        // Through mode_none so the row's mode is a real switch
        apply_inputs(addr_pkg::mode_none, 0, 1'b1);
        expect_quiet(3, "valid while passing through mode_none");
        check_value("write address after mode switch", int'(ctrl_write_addr), 0);

        take_bits(11, low_addr);
        low_addr = low_addr % row.threshold;
        apply_inputs(row.mode, low_addr, 1'b1);
        expect_quiet(row.wait_cycles, "valid below the start address");
        check_value("write address before first valid", int'(ctrl_write_addr), 0);

        apply_inputs(row.mode, row.read_addr, 1'b1);
        partial = 0;
        if (row.drop_after != 0) begin
            count_scan(0, row.drop_after, partial);
            check_value("valids before en drop", partial, row.drop_after);
            pause_enable(row, partial);
        end
        count_scan(partial, 0, count);
        check_value("valid count of scan", count, row.expected);
        check_value("final write address", int'(ctrl_write_addr), partial + row.expected);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int r;
        lfsr_state     = 16'd64;
        rst_n          <= 1'b0;
        ctrl_mode      <= addr_pkg::mode_none;
        ctrl_read_addr <= '0;
        en             <= 1'b0;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("valid after reset", int'(valid_out), 0);
        check_value("write address after reset", int'(ctrl_write_addr), 0);

        for (r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end

        run_passed = 1'b1;
        $display("Result: PASSED");
        $finish;
    end

    // Catches runs stopped by an assertion or the simulator itself
    final begin
        if (!run_passed && !fail_printed && !timed_out) begin
            $display("Run ended early on an assertion or simulator error");
            $display("Result: FAILED");
        end
    end

endmodule

`default_nettype wire

/* test/addr_controller_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_controller_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            en,
    input logic            valid_out,
    input addr_pkg::addr_t ctrl_write_addr
);

    reset_outputs_low: assert property (
        @(posedge clk) !rst_n |-> (!valid_out && ctrl_write_addr == '0)
    ) else $error("valid_out or write address not zero during reset");

    // Counts up, or clears on a mode change
    write_addr_no_decrease: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl_write_addr < $past(ctrl_write_addr)) |-> (ctrl_write_addr == '0)
    ) else $error("write address decreased to a nonzero value");

    no_valid_without_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        !en |-> !valid_out
    ) else $error("valid_out high while en is low");

endmodule

bind addr_controller addr_controller_asserts i_asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .en              (en),
    .valid_out       (valid_out),
    .ctrl_write_addr (ctrl_write_addr)
);

`default_nettype wire

/* logic/addr_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_controller (
    input  logic            clk,
    input  logic            rst_n,
    input  addr_pkg::mode_t ctrl_mode,
    input  addr_pkg::addr_t ctrl_read_addr,
    input  logic            en,
    output addr_pkg::addr_t ctrl_write_addr,
    output logic            valid_out
);

    logic conv_valid;
    logic pool_valid;

    scan_ctrl_if ctrl_bus ();

    //////////////////////////////////////////////////
    // Input registers and mode history
    //////////////////////////////////////////////////
    mode_tracker i_mode_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_mode      (ctrl_mode),
        .ctrl_read_addr (ctrl_read_addr),
        .en             (en),
        .ctrl           (ctrl_bus.tracker)
    );

    // Scanners, one per layer family
    conv_window_scan i_conv_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl_bus.scanner),
        .valid (conv_valid)
    );

    pool_window_scan i_pool_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl_bus.scanner),
        .valid (pool_valid)
    );

    write_addr_gen i_write_addr_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .mode_changed (ctrl_bus.mode_changed),
        .conv_valid   (conv_valid),
        .pool_valid   (pool_valid),
        .valid_out    (valid_out),
        .write_addr   (ctrl_write_addr)
    );

endmodule

`default_nettype wire

/* logic/write_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module write_addr_gen (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            mode_changed,
    input  logic            conv_valid,
    input  logic            pool_valid,
    output logic            valid_out,
    output addr_pkg::addr_t write_addr
);

    // At most one scanner is active for a given mode
    assign valid_out = en && (conv_valid || pool_valid);

    //////////////////////////////////////////////////
    // Write address counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_addr <= '0;
        end else begin
            if (!en) begin
                write_addr <= write_addr;
            end else if (mode_changed) begin
                write_addr <= '0;
            end else if (valid_out) begin
                write_addr <= write_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pool_window_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module pool_window_scan (
    input  logic         clk,
    input  logic         rst_n,
    scan_ctrl_if.scanner ctrl,
    output logic         valid
);

    addr_pkg::scan_state_t state_q;
    addr_pkg::scan_state_t state_d;
    addr_pkg::addr_t       row_cnt_q;
    addr_pkg::addr_t       row_cnt_d;
    addr_pkg::addr_t       col_cnt_q;
    addr_pkg::addr_t       col_cnt_d;
    addr_pkg::addr_t       last_pix;
    logic                  corner;
    logic                  hold;

    assign last_pix = addr_pkg::map_size[ctrl.mode] - 1'b1;

    // Bottom-right pixel of a 2x2 window
    assign corner = row_cnt_q[0] && col_cnt_q[0];

    assign hold = !ctrl.en || !addr_pkg::is_pool_mode[ctrl.mode] || ctrl.mode_changed;

    always_comb begin
        state_d   = state_q;
        row_cnt_d = row_cnt_q;
        col_cnt_d = col_cnt_q;

        case (state_q)
            addr_pkg::st_idle: begin
                if (ctrl.read_addr_q >= addr_pkg::start_addr[ctrl.mode]) begin
                    state_d = addr_pkg::st_valid;
                end
            end
            addr_pkg::st_valid: begin
                // Raster walk over the input map
                if (col_cnt_q < last_pix) begin
                    col_cnt_d = col_cnt_q + 1'b1;
                end else begin
                    col_cnt_d = '0;
                    if (row_cnt_q < last_pix) begin
                        row_cnt_d = row_cnt_q + 1'b1;
                    end else begin
                        state_d = addr_pkg::st_finish;
                    end
                end
            end
            addr_pkg::st_finish: begin
                state_d = addr_pkg::st_finish;
            end
            default: begin
                state_d = addr_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= addr_pkg::st_idle;
            row_cnt_q <= '0;
            col_cnt_q <= '0;
            valid     <= 1'b0;
        end else if (hold) begin
            state_q   <= addr_pkg::st_idle;
            row_cnt_q <= '0;
            col_cnt_q <= '0;
            valid     <= 1'b0;
        end else begin
            state_q   <= state_d;
            row_cnt_q <= row_cnt_d;
            col_cnt_q <= col_cnt_d;
            valid     <= (state_q == addr_pkg::st_valid) && corner;
        end
    end

endmodule

`default_nettype wire

/* logic/conv_window_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_window_scan (
    input  logic         clk,
    input  logic         rst_n,
    scan_ctrl_if.scanner ctrl,
    output logic         valid
);

    addr_pkg::scan_state_t state_q;
    addr_pkg::scan_state_t state_d;
    addr_pkg::addr_t       row_cnt_q;
    addr_pkg::addr_t       row_cnt_d;
    addr_pkg::addr_t       col_cnt_q;
    addr_pkg::addr_t       col_cnt_d;
    addr_pkg::addr_t       edge_cnt_q;
    addr_pkg::addr_t       edge_cnt_d;
    addr_pkg::addr_t       last_pos;
    logic                  hold;

    // Last window origin in a row, N-K
    assign last_pos  = addr_pkg::map_size[ctrl.mode] - addr_pkg::addr_t'(addr_pkg::kernel_size);

    assign hold = !ctrl.en || !addr_pkg::is_conv_mode[ctrl.mode] || ctrl.mode_changed;

    //////////////////////////////////////////////////
    // Next-state logic
    //////////////////////////////////////////////////
    always_comb begin
        state_d    = state_q;
        row_cnt_d  = row_cnt_q;
        col_cnt_d  = col_cnt_q;
        edge_cnt_d = edge_cnt_q;

        case (state_q)
            addr_pkg::st_idle: begin
                if (ctrl.read_addr_q >= addr_pkg::start_addr[ctrl.mode]) begin
                    state_d = addr_pkg::st_valid;
                end
            end
            addr_pkg::st_valid: begin
                if (col_cnt_q < last_pos) begin
                    col_cnt_d = col_cnt_q + 1'b1;
                end else begin
                    state_d    = addr_pkg::st_edge;
                    col_cnt_d  = '0;
                    edge_cnt_d = '0;
                end
            end
            addr_pkg::st_edge: begin
                // K-1 edge cycles per row, counted 0..K-2
                if (edge_cnt_q < addr_pkg::addr_t'(addr_pkg::kernel_size - 2)) begin
                    edge_cnt_d = edge_cnt_q + 1'b1;
                end else begin
                    row_cnt_d = row_cnt_q + 1'b1;
                    if (row_cnt_q < last_pos) begin
                        state_d = addr_pkg::st_valid;
                    end else begin
                        state_d = addr_pkg::st_finish;
                    end
                end
            end
            default: begin
                // Parked until the mode changes
                state_d = addr_pkg::st_finish;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= addr_pkg::st_idle;
            row_cnt_q  <= '0;
            col_cnt_q  <= '0;
            edge_cnt_q <= '0;
            valid      <= 1'b0;
        end else if (hold) begin
            state_q    <= addr_pkg::st_idle;
            row_cnt_q  <= '0;
            col_cnt_q  <= '0;
            edge_cnt_q <= '0;
            valid      <= 1'b0;
        end else begin
            state_q    <= state_d;
            row_cnt_q  <= row_cnt_d;
            col_cnt_q  <= col_cnt_d;
            edge_cnt_q <= edge_cnt_d;
            valid      <= (state_q == addr_pkg::st_valid);
        end
    end

endmodule

`default_nettype wire

/* logic/mode_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module mode_tracker (
    input  logic            clk,
    input  logic            rst_n,
    input  addr_pkg::mode_t ctrl_mode,
    input  addr_pkg::addr_t ctrl_read_addr,
    input  logic            en,
    scan_ctrl_if.tracker    ctrl
);

    addr_pkg::addr_t read_addr_q;
    addr_pkg::mode_t mode_q1;
    addr_pkg::mode_t mode_q2;

    // Read address register and two-deep mode history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_addr_q <= '0;
            mode_q1     <= addr_pkg::mode_none;
            mode_q2     <= addr_pkg::mode_none;
        end else begin
            read_addr_q <= ctrl_read_addr;
            mode_q1     <= ctrl_mode;
            mode_q2     <= mode_q1;
        end
    end

    assign ctrl.read_addr_q = read_addr_q;

    // One-cycle pulse, two cycles after a switch
    assign ctrl.mode_changed = (mode_q1 != mode_q2);

    // Scanners decode the live mode
    assign ctrl.mode = ctrl_mode;
    assign ctrl.en   = en;

endmodule

`default_nettype wire

/* logic/scan_ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface scan_ctrl_if;

    addr_pkg::addr_t read_addr_q;
    addr_pkg::mode_t mode;
    logic            en;
    logic            mode_changed;

    modport tracker (
        output read_addr_q,
        output mode,
        output en,
        output mode_changed
    );

    // Both scanners share this view
    modport scanner (
        input read_addr_q,
        input mode,
        input en,
        input mode_changed
    );

endinterface

`default_nettype wire

/* logic/addr_pkg.sv */
`default_nettype none

package addr_pkg;

    //////////////////////////////////////////////////
    // Widths and kernel
    //////////////////////////////////////////////////
    localparam int unsigned addr_w = 11;
    localparam int unsigned kernel_size = 5;

    typedef logic [addr_w-1:0] addr_t;

    // Layer modes as seen on ctrl_mode
    typedef enum logic [2:0] {
        mode_conv1 = 3'd0,
        mode_conv2 = 3'd1,
        mode_conv3 = 3'd2,
        mode_conv4 = 3'd3,
        mode_conv5 = 3'd4,
        mode_pool1 = 3'd5,
        mode_pool2 = 3'd6,
        mode_none  = 3'd7
    } mode_t;

    // Pooling scanner uses st_valid as its fetch state
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_valid  = 2'd1,
        st_edge   = 2'd2,
        st_finish = 2'd3
    } scan_state_t;

    //////////////////////////////////////////////////
    // Layer geometry, indexed by mode
    //////////////////////////////////////////////////
    localparam addr_t map_size [0:7] = '{
        11'd32, 11'd28, 11'd14, 11'd10, 11'd5, 11'd28, 11'd10, 11'd0
    };

    // Read address that must be reached before a scan starts
    localparam addr_t start_addr [0:7] = '{
        11'd172, 11'd156, 11'd100, 11'd84, 11'd59, 11'd87, 11'd33, 11'd2047
    };

    localparam bit is_conv_mode [0:7] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    localparam bit is_pool_mode [0:7] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

endpackage

`default_nettype wire
